// File: design/stream_pkg.sv
package stream_pkg;

    // Widths of the fields carried by one input beat
    localparam int SAMPLE_WIDTH = 16;
    localparam int DEST_WIDTH   = 8;
    localparam int USER_WIDTH   = 8;

    // Width of the tagged output word
    localparam int WORD_WIDTH = 32;

    // Bits between the destination tag and the sample that repeat the sign bit
    localparam int EXTEND_WIDTH = WORD_WIDTH - DEST_WIDTH - SAMPLE_WIDTH;

    // Number of accepted beats of one stream that make up a frame
    localparam int FRAME_LENGTH = 8;
    localparam int COUNT_WIDTH  = $clog2(FRAME_LENGTH);

    // Width of the starvation monitor counter
    localparam int STARVE_WIDTH = 16;

    // One beat as it arrives from the acquisition front end
    typedef struct packed {
        logic [SAMPLE_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0]   dest;
        logic [USER_WIDTH-1:0]   user;
    } in_beat_t;

    // One beat of the merged, tagged output stream
    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0] dest;
        logic [USER_WIDTH-1:0] user;
        logic                  last;
    } out_beat_t;

    // Decision of the arbiter for the current cycle
    // A source of zero means stream 1, one means stream 2
    typedef struct packed {
        logic     fire;
        logic     source;
        in_beat_t beat;
    } grant_t;

endpackage

// File: design/stream_arbiter.sv
`timescale 1ns/1ps

module stream_arbiter (
    input  logic                                 clock,
    input  logic                                 reset,
    input  stream_pkg::in_beat_t                 in_1,
    input  logic                                 in_1_valid,
    output logic                                 in_1_ready,
    input  stream_pkg::in_beat_t                 in_2,
    input  logic                                 in_2_valid,
    output logic                                 in_2_ready,
    input  logic                                 slot_free,
    output stream_pkg::grant_t                   grant,
    output logic [stream_pkg::STARVE_WIDTH-1:0]  starve_count
);

    logic take_1;
    logic take_2;
    logic starved;

    // Stream 1 always has first claim on a free output slot
    always_comb begin
        in_1_ready = slot_free;
        in_2_ready = slot_free & ~in_1_valid;
    end

    // A transfer happens on whichever port sees valid and ready together
    always_comb begin
        take_1 = in_1_valid & in_1_ready;
        take_2 = in_2_valid & in_2_ready;
    end

    always_comb begin
        grant.fire = take_1 | take_2;
        // Stream 2 is named only when stream 1 has nothing to offer
        grant.source = ~in_1_valid;
        if (in_1_valid) begin
            grant.beat = in_1;
        end else begin
            grant.beat = in_2;
        end
    end

    // Stream 2 loses a cycle when it is waiting and stream 1 takes the slot
    assign starved = take_1 & in_2_valid;

    // Starvation monitor for the host
    // It saturates instead of wrapping so a long run never reads as small
    always_ff @(posedge clock) begin
        if (!reset) begin
            starve_count <= '0;
        end else if (starved && (starve_count != '1)) begin
            starve_count <= starve_count + 1'b1;
        end
    end

endmodule

// File: design/frame_counter.sv
`timescale 1ns/1ps

module frame_counter (
    input  logic clock,
    input  logic reset,
    input  logic accept,
    output logic last
);

    localparam logic [stream_pkg::COUNT_WIDTH-1:0] FINAL_COUNT =
        stream_pkg::COUNT_WIDTH'(stream_pkg::FRAME_LENGTH - 1);

    // Number of beats of this stream already accepted in the current frame
    logic [stream_pkg::COUNT_WIDTH-1:0] count;
    logic                               frame_done;

    // The beat being accepted now completes the frame when the count is at its top
    assign frame_done = (count == FINAL_COUNT);

    // The mark is only meaningful while a beat of this stream is being taken
    assign last = accept & frame_done;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (accept) begin
            if (frame_done) begin
                // Start counting the next frame from its first beat
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: design/sample_formatter.sv
`timescale 1ns/1ps

module sample_formatter (
    input  logic                  clock,
    input  logic                  reset,
    input  stream_pkg::grant_t    grant,
    input  logic                  last,
    output stream_pkg::out_beat_t out,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  slot_free
);

    stream_pkg::out_beat_t next_beat;
    logic                  sign_bit;

    assign sign_bit = grant.beat.data[stream_pkg::SAMPLE_WIDTH-1];

    // Output word layout, from the top down
    // The destination tag, then copies of the sign bit, then the raw sample
    always_comb begin
        next_beat.data = {
            grant.beat.dest,
            {stream_pkg::EXTEND_WIDTH{sign_bit}},
            grant.beat.data
        };
        next_beat.dest = grant.beat.dest;
        next_beat.user = grant.beat.user;
        next_beat.last = last;
    end

    // The register can take a new beat if it is empty or is handing off its beat now
    assign slot_free = ~out_valid | out_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (grant.fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // The arbiter only fires into a free slot, so loading here never overwrites
    // a beat that is still waiting for the sink
    always_ff @(posedge clock) begin
        if (grant.fire) begin
            out <= next_beat;
        end
    end

endmodule

// File: design/stream_merge_top.sv
`timescale 1ns/1ps

module stream_merge_top (
    input  logic                                clock,
    input  logic                                reset,
    input  stream_pkg::in_beat_t                in_1,
    input  logic                                in_1_valid,
    output logic                                in_1_ready,
    input  stream_pkg::in_beat_t                in_2,
    input  logic                                in_2_valid,
    output logic                                in_2_ready,
    output stream_pkg::out_beat_t               out,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [stream_pkg::STARVE_WIDTH-1:0] starve_count
);

    stream_pkg::grant_t grant;
    logic               slot_free;
    logic               accept_1;
    logic               accept_2;
    logic               last_1;
    logic               last_2;
    logic               last;

    stream_arbiter arbiter (
        .clock        (clock),
        .reset        (reset),
        .in_1         (in_1),
        .in_1_valid   (in_1_valid),
        .in_1_ready   (in_1_ready),
        .in_2         (in_2),
        .in_2_valid   (in_2_valid),
        .in_2_ready   (in_2_ready),
        .slot_free    (slot_free),
        .grant        (grant),
        .starve_count (starve_count)
    );

    // Each counter only advances on beats taken from its own stream
    assign accept_1 = grant.fire & ~grant.source;
    assign accept_2 = grant.fire & grant.source;

    frame_counter frame_1 (
        .clock  (clock),
        .reset  (reset),
        .accept (accept_1),
        .last   (last_1)
    );

    frame_counter frame_2 (
        .clock  (clock),
        .reset  (reset),
        .accept (accept_2),
        .last   (last_2)
    );

    assign last = grant.source ? last_2 : last_1;

    sample_formatter formatter (
        .clock     (clock),
        .reset     (reset),
        .grant     (grant),
        .last      (last),
        .out       (out),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .slot_free (slot_free)
    );

endmodule

// File: bench/stream_merge_properties.sv
`timescale 1ns/1ps

module stream_merge_properties (
    input logic                  clock,
    input logic                  reset,
    input logic                  in_1_valid,
    input logic                  in_1_ready,
    input logic                  in_2_valid,
    input logic                  in_2_ready,
    input stream_pkg::out_beat_t out,
    input logic                  out_valid,
    input logic                  out_ready
);

    // Number of assertion failures seen so far
    int failures = 0;

    // A beat waiting for the sink must neither move nor change
    property hold_under_stall;
        @(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out));
    endproperty

    // Only one input may be offered the free slot at a time
    property single_ready;
        @(posedge clock) disable iff (!reset)
        (in_1_valid && in_2_valid) |-> !(in_1_ready && in_2_ready);
    endproperty

    property empty_after_reset;
        @(posedge clock) !reset |=> !out_valid;
    endproperty

    // An output beat only shows up after an input transfer
    property valid_from_transfer;
        @(posedge clock) disable iff (!reset)
        $rose(out_valid) |-> $past((in_1_valid && in_1_ready) || (in_2_valid && in_2_ready));
    endproperty

    assert property (hold_under_stall)
        else begin
            $error("Output beat changed while out_ready was low");
            failures = failures + 1;
        end
    assert property (single_ready)
        else begin
            $error("Both input readies were high with both valids high");
            failures = failures + 1;
        end
    assert property (empty_after_reset)
        else begin
            $error("out_valid was high right after reset");
            failures = failures + 1;
        end
    assert property (valid_from_transfer)
        else begin
            $error("out_valid rose without an input transfer");
            failures = failures + 1;
        end

endmodule

bind stream_merge_top stream_merge_properties handshake_checks (
    .clock      (clock),
    .reset      (reset),
    .in_1_valid (in_1_valid),
    .in_1_ready (in_1_ready),
    .in_2_valid (in_2_valid),
    .in_2_ready (in_2_ready),
    .out        (out),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
);

// File: bench/stream_merge_tb.sv
`timescale 1ns/1ps

module stream_merge_tb;

    localparam int RANDOM_TEST   = 6;
    localparam int RANDOM_CYCLES = 300;

    // One line of the stimulus file
    typedef struct packed {
        logic [7:0]                        test;
        logic [7:0]                        stream;
        stream_pkg::in_beat_t              beat;
        logic [15:0]                       stall;
        logic [stream_pkg::WORD_WIDTH-1:0] word;
    } record_t;

    logic                                clock;
    logic                                reset;
    stream_pkg::in_beat_t                in_1;
    logic                                in_1_valid;
    logic                                in_1_ready;
    stream_pkg::in_beat_t                in_2;
    logic                                in_2_valid;
    logic                                in_2_ready;
    stream_pkg::out_beat_t               out;
    logic                                out_valid;
    logic                                out_ready;
    logic [stream_pkg::STARVE_WIDTH-1:0] starve_count;

    record_t                           records[$];
    stream_pkg::out_beat_t             expected_q[$];
    logic [stream_pkg::WORD_WIDTH-1:0] word_q_1[$];
    logic [stream_pkg::WORD_WIDTH-1:0] word_q_2[$];
    stream_pkg::out_beat_t             last_pushed;
    logic                              accepted_prev;
    logic                              took_1;
    logic                              took_2;
    int                                frame_count_1;
    int                                frame_count_2;
    int                                expected_starve;
    int                                current_test;
    int                                test_errors;
    int                                total_errors;
    int                                tests_run;
    int                                tests_failed;
    int                                cycle_count;
    int                                cycle_limit;
    logic [31:0]                       random_state;

    stream_merge_top UUT (
        .clock        (clock),
        .reset        (reset),
        .in_1         (in_1),
        .in_1_valid   (in_1_valid),
        .in_1_ready   (in_1_ready),
        .in_2         (in_2),
        .in_2_valid   (in_2_valid),
        .in_2_ready   (in_2_ready),
        .out          (out),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .starve_count (starve_count)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Destination on top, then eight copies of the sign bit, then the sample
    function automatic logic [31:0] format_word(input stream_pkg::in_beat_t beat);
        return {beat.dest, {8{beat.data[15]}}, beat.data};
    endfunction

    function automatic string test_name(input int number);
        case (number)
            1:       return "single_stream";
            2:       return "priority";
            3:       return "back_pressure";
            4:       return "frame_marking";
            5:       return "latency";
            6:       return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    task automatic note_error();
        test_errors = test_errors + 1;
        total_errors = total_errors + 1;
    endtask

    // Builds the expected output beat for an input transfer seen at a port
    task automatic push_expected(input logic source, input stream_pkg::in_beat_t beat);
        stream_pkg::out_beat_t expected;
        logic [31:0]           word;
        int                    count;
        if (source == 1'b0) begin
            word = word_q_1.pop_front();
            frame_count_1 = frame_count_1 + 1;
            count = frame_count_1;
            if (frame_count_1 == stream_pkg::FRAME_LENGTH) frame_count_1 = 0;
        end else begin
            word = word_q_2.pop_front();
            frame_count_2 = frame_count_2 + 1;
            count = frame_count_2;
            if (frame_count_2 == stream_pkg::FRAME_LENGTH) frame_count_2 = 0;
        end
        expected.data = word;
        expected.dest = beat.dest;
        expected.user = beat.user;
        expected.last = (count == stream_pkg::FRAME_LENGTH);
        expected_q.push_back(expected);
        last_pushed = expected;
        accepted_prev = 1'b1;
    endtask

    always @(posedge clock) begin : monitor
        stream_pkg::out_beat_t expected;
        if (reset) begin
            // The beat taken on the previous edge must be at the output now
            if (accepted_prev) begin
                assert (out_valid) else begin
                    $display("Test %s: out_valid was low one cycle after an input transfer",
                             test_name(current_test));
                    note_error();
                end
                assert (out == last_pushed) else begin
                    $display("mismatch in test %s at one cycle latency: expected %h actual %h",
                             test_name(current_test), last_pushed, out);
                    note_error();
                end
            end
            if (out_valid && out_ready) begin
                assert (expected_q.size() != 0) else begin
                    $display("Test %s: an output beat left with no input transfer behind it",
                             test_name(current_test));
                    note_error();
                end
                if (expected_q.size() != 0) begin
                    expected = expected_q.pop_front();
                    assert (out == expected) else begin
                        $display("mismatch in test %s: expected %h actual %h",
                                 test_name(current_test), expected, out);
                        note_error();
                    end
                end
            end
            assert (!(in_1_valid && in_2_valid && in_2_ready)) else begin
                $display("Test %s: stream 2 was offered ready while stream 1 was waiting",
                         test_name(current_test));
                note_error();
            end
            accepted_prev = 1'b0;
            if (in_1_valid && in_1_ready) begin
                push_expected(1'b0, in_1);
                if (in_2_valid) expected_starve = expected_starve + 1;
            end
            if (in_2_valid && in_2_ready) push_expected(1'b1, in_2);
            took_1 <= in_1_valid && in_1_ready;
            took_2 <= in_2_valid && in_2_ready;
        end
    end

    // Moves to the next falling edge and drops the valid of any port that just transferred
    task automatic next_cycle();
        @(negedge clock);
        if (took_1) in_1_valid = 1'b0;
        if (took_2) in_2_valid = 1'b0;
    endtask

    task automatic offer(input int port, input stream_pkg::in_beat_t beat,
                         input logic [31:0] word);
        if (port == 1) begin
            while (in_1_valid) next_cycle();
            in_1 = beat;
            in_1_valid = 1'b1;
            word_q_1.push_back(word);
        end else begin
            while (in_2_valid) next_cycle();
            in_2 = beat;
            in_2_valid = 1'b1;
            word_q_2.push_back(word);
        end
    endtask

    task automatic wait_taken(input int port);
        if (port == 1) begin
            while (in_1_valid) next_cycle();
        end else begin
            while (in_2_valid) next_cycle();
        end
    endtask

    task automatic run_record(input record_t rec);
        if (rec.stall != 0) begin
            out_ready = 1'b0;
            repeat (rec.stall) next_cycle();
            out_ready = 1'b1;
        end
        case (rec.stream)
            8'd1: begin
                offer(1, rec.beat, rec.word);
                wait_taken(1);
            end
            8'd2: begin
                offer(2, rec.beat, rec.word);
                wait_taken(2);
            end
            // Left pending on stream 2 while the records that follow go to stream 1
            default: offer(2, rec.beat, rec.word);
        endcase
    endtask

    task automatic finish_test(input int number);
        out_ready = 1'b1;
        while (in_1_valid || in_2_valid || expected_q.size() != 0) next_cycle();
        assert (starve_count == 16'(expected_starve)) else begin
            $display("mismatch in test %s on starve_count: expected %0d actual %0d",
                     test_name(number), expected_starve, starve_count);
            note_error();
        end
        tests_run = tests_run + 1;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", number, test_name(number));
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d %s: %0d errors", number, test_name(number), test_errors);
        end
        test_errors = 0;
    endtask

    task automatic load_records();
        int                   fd;
        int                   n;
        int                   test_number;
        int                   stream;
        int                   stall;
        string                line;
        logic [15:0]          data;
        logic [7:0]           dest;
        logic [7:0]           user;
        logic [31:0]          word;
        record_t              rec;
        fd = $fopen("bench/merge_stimulus.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %h %h %h %d %h",
                            test_number, stream, data, dest, user, stall, word);
                if (n == 7) begin
                    rec.test = 8'(test_number);
                    rec.stream = 8'(stream);
                    rec.beat.data = data;
                    rec.beat.dest = dest;
                    rec.beat.user = user;
                    rec.stall = 16'(stall);
                    rec.word = word;
                    records.push_back(rec);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_random();
        stream_pkg::in_beat_t beat;
        logic [31:0]          r;
        repeat (RANDOM_CYCLES) begin
            next_cycle();
            random_state = xorshift(random_state);
            r = random_state;
            if (!in_1_valid && r[0]) begin
                random_state = xorshift(random_state);
                beat = random_state;
                offer(1, beat, format_word(beat));
            end
            if (!in_2_valid && r[1]) begin
                random_state = xorshift(random_state);
                beat = random_state;
                offer(2, beat, format_word(beat));
            end
            // The sink accepts about three cycles out of four
            out_ready = (r[3:2] != 2'b00);
        end
    endtask

    task automatic run_tests();
        int stall_total;
        stall_total = 0;
        foreach (records[i]) stall_total = stall_total + records[i].stall;
        cycle_limit = 4 * (records.size() + stall_total + RANDOM_CYCLES) + 100;
        repeat (8) @(negedge clock);
        reset = 1'b1;
        current_test = records[0].test;
        foreach (records[i]) begin
            if (records[i].test != current_test) begin
                finish_test(current_test);
                current_test = records[i].test;
            end
            run_record(records[i]);
        end
        finish_test(current_test);
        current_test = RANDOM_TEST;
        run_random();
        finish_test(RANDOM_TEST);
    endtask

    initial begin
        reset = 1'b0;
        in_1 = '0;
        in_1_valid = 1'b0;
        in_2 = '0;
        in_2_valid = 1'b0;
        out_ready = 1'b1;
        accepted_prev = 1'b0;
        took_1 = 1'b0;
        took_2 = 1'b0;
        frame_count_1 = 0;
        frame_count_2 = 0;
        expected_starve = 0;
        current_test = 0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        cycle_limit = 100000;
        random_state = 32'd4;
        load_records();
        if (records.size() == 0) begin
            $display("No records could be read from bench/merge_stimulus.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            run_tests();
            // Handshake assertions that fired in the bound checker count as errors too
            total_errors = total_errors + UUT.handshake_checks.failures;
            $display("Summary: %0d tests run, %0d failed, %0d errors",
                     tests_run, tests_failed, total_errors);
            if (total_errors == 0 && tests_failed == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

// File: bench/merge_stimulus.txt
# Columns: test stream data dest user stall expected_word (test, stream, stall decimal; rest hex)
# Stream 1 or 2 waits for its transfer, stream 3 stays pending on stream 2 beside what follows
1 1 0012 a1 01 0 a1000012
1 1 8000 a1 02 0 a1ff8000
1 1 ffff a2 03 0 a2ffffff
1 1 7fff a2 04 0 a2007fff
1 2 fe10 b1 11 0 b1fffe10
1 2 0001 b1 12 0 b1000001
1 2 c350 b2 13 0 b2ffc350
1 2 3039 b2 14 0 b2003039
2 3 1111 c2 21 0 c2001111
2 1 2222 c1 22 0 c1002222
2 1 a333 c1 23 0 c1ffa333
2 1 4444 c1 24 0 c1004444
2 3 9555 c2 25 0 c2ff9555
2 1 6666 c1 26 0 c1006666
2 1 e777 c1 27 0 c1ffe777
3 1 0a0a d1 31 3 d1000a0a
3 2 8a8a d2 32 2 d2ff8a8a
3 1 1b1b d1 33 0 d1001b1b
3 3 fc0c d2 34 4 d2fffc0c
3 1 2d2d d1 35 1 d1002d2d
3 2 5e5e d2 36 5 d2005e5e
3 1 bfbf d1 37 2 d1ffbfbf
4 1 0100 e1 41 0 e1000100
4 2 f200 e2 42 0 e2fff200
4 1 0300 e1 43 0 e1000300
4 2 f400 e2 44 0 e2fff400
4 1 0500 e1 45 0 e1000500
4 2 f600 e2 46 0 e2fff600
4 1 0700 e1 47 0 e1000700
4 2 f800 e2 48 0 e2fff800
4 1 0900 e1 49 0 e1000900
4 2 fa00 e2 4a 0 e2fffa00
4 1 0b00 e1 4b 0 e1000b00
4 2 fc00 e2 4c 0 e2fffc00
4 1 0d00 e1 4d 0 e1000d00
4 2 fe00 e2 4e 0 e2fffe00
4 1 0f00 e1 4f 0 e1000f00
4 2 8000 e2 50 0 e2ff8000
4 1 1100 e1 51 0 e1001100
4 2 9200 e2 52 0 e2ff9200
4 1 1300 e1 53 0 e1001300
4 2 a400 e2 54 0 e2ffa400
5 1 0055 f1 61 0 f1000055
5 1 8055 f1 62 0 f1ff8055
5 2 00aa f2 63 0 f20000aa
5 2 80aa f2 64 0 f2ff80aa
5 1 1234 f1 65 0 f1001234
5 2 edcb f2 66 0 f2ffedcb
5 1 7654 f1 67 0 f1007654
5 2 89ab f2 68 0 f2ff89ab

// File: list.f
design/stream_pkg.sv
design/stream_arbiter.sv
design/frame_counter.sv
design/sample_formatter.sv
design/stream_merge_top.sv
bench/stream_merge_properties.sv
bench/stream_merge_tb.sv
